// File: dcache_l1.f
verilog/dcache_pkg.sv
verilog/line_store.sv
verilog/store_align.sv
verilog/cache_way.sv
verilog/way_select.sv
verilog/fill_control.sv
verilog/dcache_l1.sv
tests/dcache_l1_props.sv
tests/dcache_l1_checker.sv
tests/dcache_l1_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the dcache_l1 testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module dcache_l1_tb -f dcache_l1.f -o dcache_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/dcache_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && exit 1
grep -q "TEST RESULT: PASS" sim.log || exit 1
exit 0

// File: tests/dcache_l1_tb.sv
/*
 * Testbench for the L1 data cache: builds a table of stimulus rows
 * with hand-derived expectations and applies one row per clock.
 */
module dcache_l1_tb import dcache_pkg::*; ();

	typedef struct packed {
		logic ld_v;
		logic [ADDR_BITS-1:0] ld_a;
		logic st_en;
		logic [ADDR_BITS-1:0] st_a;
		logic [WORD_BITS-1:0] st_d;
		logic [WORD_BYTES-1:0] st_m;
		logic fl_req;
		line_addr_t fl_a;
		line_t fl_d;
		logic [2:0] fl_resp;
		logic ack;
		logic e_hit;
		logic [WORD_BITS-1:0] e_ld;
		logic e_ok;
		logic e_inval;
		logic e_wait;
		logic e_ack;
		logic e_wb;
		line_addr_t e_wba;
		line_t e_wbd;
	} row_t;

	logic clk;
	logic reset;
	logic active;
	row_t cur;
	row_t r;
	row_t rows [$];

	// load results show up one row later
	logic nx_hit;
	logic want_hit;
	logic [WORD_BITS-1:0] nx_data;
	logic [WORD_BITS-1:0] want_data;
	logic exp_wb;
	line_addr_t exp_wba;
	line_t exp_wbd;

	int seed = 81858;
	int rnd;
	int cycles = 0;
	int cycle_limit = 0;
	int mismatches;
	int checks;
	int total_errors;

	logic load_hit;
	logic [WORD_BITS-1:0] load_data;
	logic store_ok;
	logic store_must_inval;
	logic store_wait;
	logic fill_ack;
	logic wb_req;
	line_addr_t wb_addr;
	line_t wb_data;

	dcache_l1 DUT (
		.clk(clk),
		.reset(reset),
		.load_valid(cur.ld_v),
		.load_addr(cur.ld_a),
		.load_hit(load_hit),
		.load_data(load_data),
		.store_en(cur.st_en),
		.store_addr(cur.st_a[ADDR_BITS-1:WORD_OFF_BITS]),
		.store_data(cur.st_d),
		.store_mask(cur.st_m),
		.store_ok(store_ok),
		.store_must_inval(store_must_inval),
		.store_wait(store_wait),
		.fill_req(cur.fl_req),
		.fill_addr(cur.fl_a),
		.fill_data(cur.fl_d),
		.fill_resp(cur.fl_resp),
		.fill_ack(fill_ack),
		.wb_req(wb_req),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.wb_ack(cur.ack)
	);

	bind dcache_l1 dcache_l1_props u_props (
		.clk(clk),
		.reset(reset),
		.wb_req(wb_req),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.wb_ack(wb_ack),
		.fill_en(fill_en),
		.store_ok(store_ok),
		.store_must_inval(store_must_inval)
	);

	dcache_l1_checker u_check (
		.clk(clk),
		.active(active),
		.chk_st(cur.st_en),
		.chk_fl(cur.fl_req),
		.e_hit(cur.e_hit),
		.e_ld(cur.e_ld),
		.e_ok(cur.e_ok),
		.e_inval(cur.e_inval),
		.e_wait(cur.e_wait),
		.e_ack(cur.e_ack),
		.e_wb(cur.e_wb),
		.e_wba(cur.e_wba),
		.e_wbd(cur.e_wbd),
		.load_hit(load_hit),
		.load_data(load_data),
		.store_ok(store_ok),
		.store_must_inval(store_must_inval),
		.store_wait(store_wait),
		.fill_ack(fill_ack),
		.wb_req(wb_req),
		.wb_addr(wb_addr),
		.wb_data(wb_data),
		.errors(mismatches),
		.checks(checks)
	);

	// every word carries its own tag, index and word number
	function automatic line_t line_of(tag_t tag, index_t idx);
		line_t l;
		for (int w = 0; w < WORDS_PER_LINE; w++)
			l[w*WORD_BITS +: WORD_BITS] = {tag, idx, 4'(w), 8'h5a};
		return l;
	endfunction

	function automatic logic [WORD_BITS-1:0] word_of(tag_t tag, index_t idx, int w);
		line_t l;
		l = line_of(tag, idx);
		return l[w*WORD_BITS +: WORD_BITS];
	endfunction

	function automatic logic [WORD_BITS-1:0] merge_word(logic [WORD_BITS-1:0] old,
			logic [WORD_BITS-1:0] data, logic [WORD_BYTES-1:0] mask);
		logic [WORD_BITS-1:0] m;
		m = old;
		for (int b = 0; b < WORD_BYTES; b++) begin
			if (mask[b])
				m[b*8 +: 8] = data[b*8 +: 8];
		end
		return m;
	endfunction

	function automatic logic [ADDR_BITS-1:0] byte_addr(tag_t tag, index_t idx, int w);
		return {tag, idx, WORD_SEL_BITS'(w), {WORD_OFF_BITS{1'b0}}};
	endfunction

	task automatic load_at(tag_t tag, index_t idx, int w, logic hit);
		r.ld_v = 1'b1;
		r.ld_a = byte_addr(tag, idx, w);
		want_hit = hit;
		want_data = word_of(tag, idx, w);
	endtask

	task automatic store_to(tag_t tag, index_t idx, int w, logic [WORD_BITS-1:0] data,
			logic [WORD_BYTES-1:0] mask, logic ok, logic inval, logic wt);
		r.st_en = 1'b1;
		r.st_a = byte_addr(tag, idx, w);
		r.st_d = data;
		r.st_m = mask;
		r.e_ok = ok;
		r.e_inval = inval;
		r.e_wait = wt;
	endtask

	task automatic fill_line(tag_t tag, index_t idx, logic [2:0] resp, logic ack_exp);
		r.fl_req = 1'b1;
		r.fl_a = {tag, idx};
		r.fl_d = line_of(tag, idx);
		r.fl_resp = resp;
		r.e_ack = ack_exp;
	endtask

	task automatic expect_wb(tag_t tag, index_t idx, line_t data);
		exp_wb = 1'b1;
		exp_wba = {tag, idx};
		exp_wbd = data;
	endtask

	task automatic push_row();
		r.e_hit = nx_hit;
		r.e_ld = nx_data;
		r.e_wb = exp_wb;
		r.e_wba = exp_wba;
		r.e_wbd = exp_wbd;
		if (!exp_wb && !r.ack) begin
			rnd = $random(seed);
			r.ack = rnd[0];	// no effect while nothing is pending
		end
		rows.push_back(r);
		nx_hit = r.ld_v && want_hit;
		nx_data = want_data;
		want_hit = 1'b0;
		r = '0;
	endtask

	task automatic build_table();
		line_t victim;
		// empty cache, then a shared line in set 3
		load_at(16'h1234, 4'd3, 0, 1'b0);
		push_row();
		fill_line(16'h1234, 4'd3, 3'b000, 1'b1);
		push_row();
		for (int w = 0; w < WORDS_PER_LINE; w++) begin
			load_at(16'h1234, 4'd3, w, 1'b1);
			push_row();
		end
		load_at(16'h4321, 4'd3, 0, 1'b0);	// same set, other tag
		push_row();
		store_to(16'h1234, 4'd3, 1, 32'h11223344, 4'hf, 1'b0, 1'b1, 1'b0);
		push_row();
		load_at(16'h1234, 4'd3, 1, 1'b1);
		push_row();
		store_to(16'h4321, 4'd3, 0, 32'h11223344, 4'hf, 1'b0, 1'b0, 1'b0);	// absent
		push_row();
		// exclusive line, first store makes it modified
		fill_line(16'h2000, 4'd3, 3'b010, 1'b1);
		push_row();
		store_to(16'h2000, 4'd3, 1, 32'hdeadbeef, 4'b0101, 1'b1, 1'b0, 1'b0);
		push_row();
		load_at(16'h2000, 4'd3, 1, 1'b1);
		want_data = merge_word(word_of(16'h2000, 4'd3, 1), 32'hdeadbeef, 4'b0101);
		push_row();
		store_to(16'h2000, 4'd3, 2, 32'hcafef00d, 4'hf, 1'b1, 1'b0, 1'b0);
		push_row();
		load_at(16'h2000, 4'd3, 2, 1'b1);
		want_data = 32'hcafef00d;
		push_row();
		// refresh of the stored way beats the store
		fill_line(16'h2000, 4'd3, 3'b010, 1'b1);
		store_to(16'h2000, 4'd3, 0, 32'h55aa55aa, 4'hf, 1'b1, 1'b0, 1'b1);
		push_row();
		load_at(16'h2000, 4'd3, 0, 1'b1);
		push_row();
		load_at(16'h2000, 4'd3, 1, 1'b1);
		push_row();
		// set 5 filled as M, E, S, M
		fill_line(16'h00a0, 4'd5, 3'b100, 1'b1);
		push_row();
		fill_line(16'h00a1, 4'd5, 3'b010, 1'b1);
		push_row();
		fill_line(16'h00a2, 4'd5, 3'b000, 1'b1);
		push_row();
		fill_line(16'h00a3, 4'd5, 3'b100, 1'b1);
		push_row();
		fill_line(16'h00a4, 4'd5, 3'b010, 1'b1);	// evicts way 0, dirty
		push_row();
		expect_wb(16'h00a0, 4'd5, line_of(16'h00a0, 4'd5));
		load_at(16'h00a0, 4'd5, 0, 1'b0);
		push_row();
		load_at(16'h00a4, 4'd5, 3, 1'b1);
		push_row();
		fill_line(16'h00a5, 4'd5, 3'b000, 1'b1);	// clean victims
		push_row();
		fill_line(16'h00a6, 4'd5, 3'b000, 1'b1);
		push_row();
		// way 3 is dirty and the write-back slot is busy
		repeat (2) begin
			fill_line(16'h00a7, 4'd5, 3'b010, 1'b0);
			push_row();
		end
		fill_line(16'h00b0, 4'd6, 3'b010, 1'b1);	// vacant way
		push_row();
		fill_line(16'h00a4, 4'd5, 3'b010, 1'b1);	// refresh
		push_row();
		fill_line(16'h00a7, 4'd5, 3'b010, 1'b1);
		r.ack = 1'b1;
		push_row();
		expect_wb(16'h00a3, 4'd5, line_of(16'h00a3, 4'd5));
		r.ack = 1'b1;
		push_row();
		exp_wb = 1'b0;
		store_to(16'h00a4, 4'd5, 0, 32'h0badcafe, 4'b0011, 1'b1, 1'b0, 1'b0);
		push_row();
		victim = line_of(16'h00a4, 4'd5);
		victim[WORD_BITS-1:0] = merge_word(victim[WORD_BITS-1:0], 32'h0badcafe, 4'b0011);
		fill_line(16'h00a8, 4'd5, 3'b000, 1'b1);	// pointer wrapped to way 0
		push_row();
		expect_wb(16'h00a4, 4'd5, victim);
		push_row();
		r.ack = 1'b1;
		push_row();
		exp_wb = 1'b0;
		load_at(16'h00a8, 4'd5, 2, 1'b1);
		push_row();
		load_at(16'h00a4, 4'd5, 0, 1'b0);
		push_row();
		push_row();
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("dcache_l1_tb: timeout after %0d cycles, table not finished", cycles);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		cur = '0;
		r = '0;
		reset = 1'b1;
		active = 1'b0;
		nx_hit = 1'b0;
		want_hit = 1'b0;
		nx_data = '0;
		want_data = '0;
		exp_wb = 1'b0;
		exp_wba = '0;
		exp_wbd = '0;
		build_table();
		cycle_limit = rows.size() * 4;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < rows.size(); i++) begin
			cur = rows[i];
			active = 1'b1;
			@(negedge clk);
		end
		cur = '0;
		active = 1'b0;
		total_errors = mismatches + DUT.u_props.fail_count;
		$display("dcache_l1_tb: %0d rows, %0d checks, %0d mismatches, %0d assertion failures",
			rows.size(), checks, mismatches, DUT.u_props.fail_count);
		if (total_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: tests/dcache_l1_checker.sv
/*
 * Result checker for the L1 data cache testbench.
 * Compares the cache outputs with the expected row values on each rising edge.
 */
module dcache_l1_checker import dcache_pkg::*; (
	input  logic clk,
	input  logic active,
	input  logic chk_st,
	input  logic chk_fl,
	input  logic e_hit,
	input  logic [WORD_BITS-1:0] e_ld,
	input  logic e_ok,
	input  logic e_inval,
	input  logic e_wait,
	input  logic e_ack,
	input  logic e_wb,
	input  line_addr_t e_wba,
	input  line_t e_wbd,
	input  logic load_hit,
	input  logic [WORD_BITS-1:0] load_data,
	input  logic store_ok,
	input  logic store_must_inval,
	input  logic store_wait,
	input  logic fill_ack,
	input  logic wb_req,
	input  line_addr_t wb_addr,
	input  line_t wb_data,
	output int errors,
	output int checks
);

	int err_count = 0;
	int check_count = 0;

	assign errors = err_count;
	assign checks = check_count;

	task automatic compare(input string name, input line_t got, input line_t want);
		check_count = check_count + 1;
		if (got !== want) begin
			err_count = err_count + 1;
			$display("Mismatch at time %0t: %s is %0h, expected %0h", $time, name, got, want);
		end
	endtask

	always @(posedge clk) begin
		if (active) begin
			compare("load_hit", LINE_BITS'(load_hit), LINE_BITS'(e_hit));
			if (e_hit)
				compare("load_data", LINE_BITS'(load_data), LINE_BITS'(e_ld));
			if (chk_st) begin
				compare("store_ok", LINE_BITS'(store_ok), LINE_BITS'(e_ok));
				compare("store_must_inval", LINE_BITS'(store_must_inval), LINE_BITS'(e_inval));
				compare("store_wait", LINE_BITS'(store_wait), LINE_BITS'(e_wait));
			end
			if (chk_fl)
				compare("fill_ack", LINE_BITS'(fill_ack), LINE_BITS'(e_ack));
			compare("wb_req", LINE_BITS'(wb_req), LINE_BITS'(e_wb));
			if (e_wb) begin	// payload only means something while requested
				compare("wb_addr", LINE_BITS'(wb_addr), LINE_BITS'(e_wba));
				compare("wb_data", wb_data, e_wbd);
			end
		end
	end

endmodule

// File: tests/dcache_l1_props.sv
/*
 * Handshake and state properties of the L1 data cache,
 * bound into the cache top level.
 */
module dcache_l1_props import dcache_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic wb_req,
	input  line_addr_t wb_addr,
	input  line_t wb_data,
	input  logic wb_ack,
	input  way_vec_t fill_en,
	input  logic store_ok,
	input  logic store_must_inval
);

	int fail_count = 0;

	// a pending write-back holds still until it is acknowledged
	wb_hold: assert property (@(posedge clk) disable iff (reset)
			wb_req && !wb_ack |=> wb_req && $stable(wb_addr) && $stable(wb_data))
		else begin
			$error("write-back request changed before its acknowledge");
			fail_count = fail_count + 1;
		end

	fill_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(fill_en))
		else begin
			$error("fill enables more than one way");
			fail_count = fail_count + 1;
		end

	store_status: assert property (@(posedge clk) disable iff (reset)
			!(store_ok && store_must_inval))
		else begin
			$error("store reported both writable and shared");
			fail_count = fail_count + 1;
		end

endmodule

// File: verilog/dcache_l1.sv
/*
 * L1 data cache top: set-associative, MOESI states.
 * One load port, one store port, line fill and write-back.
 */
module dcache_l1 import dcache_pkg::*; (
	input  logic clk,
	input  logic reset,

	input  logic load_valid,
	input  logic [ADDR_BITS-1:0] load_addr,
	output logic load_hit,
	output logic [WORD_BITS-1:0] load_data,

	input  logic store_en,
	input  logic [ADDR_BITS-1:WORD_OFF_BITS] store_addr,	// word address
	input  logic [WORD_BITS-1:0] store_data,
	input  logic [WORD_BYTES-1:0] store_mask,
	output logic store_ok,
	output logic store_must_inval,
	output logic store_wait,

	input  logic fill_req,
	input  line_addr_t fill_addr,
	input  line_t fill_data,
	input  logic [2:0] fill_resp,
	output logic fill_ack,

	output logic wb_req,
	output line_addr_t wb_addr,
	output line_t wb_data,
	input  logic wb_ack
);

	byte_en_t store_byte_en;
	line_t store_line;

	way_vec_t load_match;
	line_t load_line [NUM_WAYS];
	way_vec_t store_writable;
	way_vec_t store_shared;
	way_vec_t fill_match;
	way_vec_t fill_vacant;
	way_vec_t victim_dirty;
	tag_t victim_tag [NUM_WAYS];
	line_t victim_line [NUM_WAYS];
	way_vec_t fill_en;
	moesi_t fill_state;

	store_align u_align (
		.store_en(store_en),
		.store_addr(store_addr),
		.store_data(store_data),
		.store_mask(store_mask),
		.store_byte_en(store_byte_en),
		.store_line(store_line)
	);

	for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
		cache_way u_way (
			.clk(clk),
			.reset(reset),
			.load_addr(load_addr),
			.store_addr(store_addr),
			.store_en(store_en),
			.store_byte_en(store_byte_en),
			.store_line(store_line),
			.fill_addr(fill_addr),
			.fill_data(fill_data),
			.fill_state(fill_state),
			.fill_en(fill_en[w]),
			.load_match(load_match[w]),
			.load_line(load_line[w]),
			.store_writable(store_writable[w]),
			.store_shared(store_shared[w]),
			.fill_match(fill_match[w]),
			.fill_vacant(fill_vacant[w]),
			.victim_dirty(victim_dirty[w]),
			.victim_tag(victim_tag[w]),
			.victim_line(victim_line[w])
		);
	end

	way_select u_select (
		.clk(clk),
		.reset(reset),
		.load_valid(load_valid),
		.load_addr(load_addr),
		.load_match(load_match),
		.load_line(load_line),
		.store_writable(store_writable),
		.store_shared(store_shared),
		.fill_en(fill_en),
		.load_hit(load_hit),
		.load_data(load_data),
		.store_ok(store_ok),
		.store_must_inval(store_must_inval),
		.store_wait(store_wait)
	);

	fill_control u_fill (
		.clk(clk),
		.reset(reset),
		.fill_req(fill_req),
		.fill_resp(fill_resp),
		.fill_match(fill_match),
		.fill_vacant(fill_vacant),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.victim_line(victim_line),
		.fill_index(fill_addr[INDEX_BITS-1:0]),
		.wb_ack(wb_ack),
		.fill_ack(fill_ack),
		.fill_en(fill_en),
		.fill_state(fill_state),
		.wb_req(wb_req),
		.wb_addr(wb_addr),
		.wb_data(wb_data)
	);

endmodule

// File: verilog/fill_control.sv
/*
 * Fill control: chooses refresh, vacant or round-robin victim way,
 * decodes the new line state and holds the write-back request.
 */
module fill_control import dcache_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic fill_req,
	input  logic [2:0] fill_resp,
	input  way_vec_t fill_match,
	input  way_vec_t fill_vacant,
	input  way_vec_t victim_dirty,
	input  tag_t victim_tag [NUM_WAYS],
	input  line_t victim_line [NUM_WAYS],
	input  index_t fill_index,
	input  logic wb_ack,
	output logic fill_ack,
	output way_vec_t fill_en,
	output moesi_t fill_state,
	output logic wb_req,
	output line_addr_t wb_addr,
	output line_t wb_data
);

	logic [WAY_BITS-1:0] next_victim;
	logic [WAY_BITS-1:0] fill_way;
	logic evict;
	logic need_wb;
	logic take;

	// match beats vacant beats victim
	always_comb begin
		fill_way = next_victim;
		evict = 1'b1;
		for (int w = NUM_WAYS-1; w >= 0; w--) begin
			if (fill_vacant[w]) begin
				fill_way = WAY_BITS'(w);
				evict = 1'b0;
			end
		end
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (fill_match[w]) begin
				fill_way = WAY_BITS'(w);
				evict = 1'b0;
			end
		end
	end

	assign need_wb = evict && victim_dirty[next_victim];
	assign fill_ack = !(need_wb && wb_req && !wb_ack);	// write-back slot still busy
	assign take = fill_req && fill_ack;
	assign fill_en = take ? (way_vec_t'(1) << fill_way) : '0;

	always_comb begin
		if (fill_resp[2])
			fill_state = ST_M;
		else if (fill_resp[1])
			fill_state = ST_E;
		else
			fill_state = ST_S;
	end

	always_ff @(posedge clk) begin
		if (reset)
			next_victim <= '0;
		else if (take && evict)
			next_victim <= next_victim + 1'b1;	// wraps
	end

	always_ff @(posedge clk) begin
		if (reset)
			wb_req <= 1'b0;
		else if (take && need_wb)
			wb_req <= 1'b1;
		else if (wb_ack)
			wb_req <= 1'b0;
	end

	// victim payload, loaded only with a new request
	always_ff @(posedge clk) begin
		if (take && need_wb) begin
			wb_addr <= {victim_tag[next_victim], fill_index};
			wb_data <= victim_line[next_victim];
		end
	end

endmodule

// File: verilog/way_select.sv
/*
 * Way merge: picks the hitting way and the addressed word for the
 * registered load result, and forms the store status flags.
 */
module way_select import dcache_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic load_valid,
	input  logic [ADDR_BITS-1:0] load_addr,
	input  way_vec_t load_match,
	input  line_t load_line [NUM_WAYS],
	input  way_vec_t store_writable,
	input  way_vec_t store_shared,
	input  way_vec_t fill_en,
	output logic load_hit,
	output logic [WORD_BITS-1:0] load_data,
	output logic store_ok,
	output logic store_must_inval,
	output logic store_wait
);

	line_t hit_line;
	logic [WORD_SEL_BITS-1:0] word_sel;
	logic [WORD_BITS-1:0] hit_word;

	// at most one way matches a given line
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (load_match[w])
				hit_line = load_line[w];
		end
	end

	assign word_sel = load_addr[WORD_OFF_BITS +: WORD_SEL_BITS];
	assign hit_word = hit_line[word_sel*WORD_BITS +: WORD_BITS];

	always_ff @(posedge clk) begin
		if (reset)
			load_hit <= 1'b0;
		else
			load_hit <= load_valid && (|load_match);
	end

	always_ff @(posedge clk) begin
		if (load_valid)
			load_data <= hit_word;
	end

	assign store_ok = |store_writable;
	assign store_must_inval = |store_shared;
	assign store_wait = |(store_writable & fill_en);	// fill took the way this cycle

endmodule

// File: verilog/cache_way.sv
/*
 * One cache way: tag and data arrays plus line states.
 * Hit detection on the load, store and fill indexes, fill and store writes.
 */
module cache_way import dcache_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic [ADDR_BITS-1:0] load_addr,
	input  logic [ADDR_BITS-1:WORD_OFF_BITS] store_addr,
	input  logic store_en,
	input  byte_en_t store_byte_en,
	input  line_t store_line,
	input  line_addr_t fill_addr,
	input  line_t fill_data,
	input  moesi_t fill_state,
	input  logic fill_en,
	output logic load_match,
	output line_t load_line,
	output logic store_writable,
	output logic store_shared,
	output logic fill_match,
	output logic fill_vacant,
	output logic victim_dirty,
	output tag_t victim_tag,
	output line_t victim_line
);

	moesi_t state [NUM_SETS];

	index_t ld_idx, st_idx, fl_idx;
	tag_t ld_tag, st_tag, fl_tag;
	tag_t ld_tag_rd;
	tag_t st_tag_rd;
	moesi_t ld_state, st_state, fl_state;
	line_t st_line_rd;
	line_t store_merged;
	logic store_write;
	index_t data_waddr;
	line_t data_wdata;

	assign ld_idx = load_addr[OFFSET_BITS +: INDEX_BITS];
	assign ld_tag = load_addr[TAG_LSB +: TAG_BITS];
	assign st_idx = store_addr[OFFSET_BITS +: INDEX_BITS];
	assign st_tag = store_addr[TAG_LSB +: TAG_BITS];
	assign fl_idx = fill_addr[INDEX_BITS-1:0];
	assign fl_tag = fill_addr[INDEX_BITS +: TAG_BITS];

	line_store #(.payload_t(tag_t)) u_tags (
		.clk(clk),
		.we(fill_en),
		.waddr(fl_idx),
		.wdata(fl_tag),
		.raddr_a(ld_idx),
		.raddr_b(st_idx),
		.raddr_c(fl_idx),
		.rdata_a(ld_tag_rd),
		.rdata_b(st_tag_rd),
		.rdata_c(victim_tag)
	);

	line_store #(.payload_t(line_t)) u_data (
		.clk(clk),
		.we(fill_en | store_write),
		.waddr(data_waddr),
		.wdata(data_wdata),
		.raddr_a(ld_idx),
		.raddr_b(st_idx),
		.raddr_c(fl_idx),
		.rdata_a(load_line),
		.rdata_b(st_line_rd),
		.rdata_c(victim_line)
	);

	assign ld_state = state[ld_idx];
	assign st_state = state[st_idx];
	assign fl_state = state[fl_idx];

	assign load_match = (ld_state != ST_I) && (ld_tag_rd == ld_tag);
	assign store_writable = (st_state == ST_E || st_state == ST_M) && (st_tag_rd == st_tag);
	assign store_shared = (st_state != ST_I) && st_state[SHARED_BIT] && (st_tag_rd == st_tag);
	assign fill_match = (fl_state != ST_I) && (victim_tag == fl_tag);
	assign fill_vacant = (fl_state == ST_I);
	assign victim_dirty = fl_state[DIRTY_BIT];

	// fill has priority, store is retried
	assign store_write = store_en && store_writable && !fill_en;

	always_comb begin
		store_merged = st_line_rd;
		for (int b = 0; b < LINE_BYTES; b++) begin
			if (store_byte_en[b])
				store_merged[b*8 +: 8] = store_line[b*8 +: 8];
		end
	end

	assign data_waddr = fill_en ? fl_idx : st_idx;
	assign data_wdata = fill_en ? fill_data : store_merged;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_SETS; i++)
				state[i] <= ST_I;
		end else if (fill_en) begin
			state[fl_idx] <= fill_state;
		end else if (store_write && st_state == ST_E) begin
			state[st_idx] <= ST_M;	// first write dirties the line
		end
	end

endmodule

// File: verilog/store_align.sv
/*
 * Store alignment: places the word byte mask at its position
 * in the line and replicates the store word across the line.
 */
module store_align import dcache_pkg::*; (
	input  logic store_en,
	input  logic [ADDR_BITS-1:WORD_OFF_BITS] store_addr,
	input  logic [WORD_BITS-1:0] store_data,
	input  logic [WORD_BYTES-1:0] store_mask,
	output byte_en_t store_byte_en,
	output line_t store_line
);

	logic [WORD_SEL_BITS-1:0] word_sel;
	int unsigned byte_shift;

	assign word_sel = store_addr[WORD_OFF_BITS +: WORD_SEL_BITS];

	always_comb begin
		byte_shift = int'(word_sel) * WORD_BYTES;
		if (store_en) begin
			store_byte_en = byte_en_t'(store_mask) << byte_shift;
		end else begin
			store_byte_en = '0;	// nothing written
		end
	end

	// every word slot gets the same data, byte enables pick the slot
	assign store_line = {WORDS_PER_LINE{store_data}};

endmodule

// File: verilog/line_store.sv
/*
 * Small entry array for any payload, one entry per set.
 * One clocked write port and three asynchronous read ports.
 */
module line_store import dcache_pkg::*; #(
	parameter type payload_t = line_t
) (
	input  logic clk,
	input  logic we,
	input  index_t waddr,
	input  payload_t wdata,
	input  index_t raddr_a,
	input  index_t raddr_b,
	input  index_t raddr_c,
	output payload_t rdata_a,
	output payload_t rdata_b,
	output payload_t rdata_c
);

	payload_t mem [NUM_SETS];

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	assign rdata_a = mem[raddr_a];	// load
	assign rdata_b = mem[raddr_b];	// store
	assign rdata_c = mem[raddr_c];	// fill / victim

endmodule

// File: verilog/dcache_pkg.sv
/*
 * L1 data cache shared definitions: sizes, address fields,
 * MOESI line state encoding and common payload types.
 */
package dcache_pkg;

	localparam int ADDR_BITS = 24;		// physical byte address
	localparam int WORD_BITS = 32;
	localparam int WORD_BYTES = WORD_BITS / 8;
	localparam int WORD_OFF_BITS = $clog2(WORD_BYTES);
	localparam int LINE_BYTES = 16;
	localparam int LINE_BITS = LINE_BYTES * 8;
	localparam int WORDS_PER_LINE = LINE_BITS / WORD_BITS;
	localparam int WORD_SEL_BITS = $clog2(WORDS_PER_LINE);
	localparam int OFFSET_BITS = $clog2(LINE_BYTES);
	localparam int NUM_SETS = 16;
	localparam int INDEX_BITS = $clog2(NUM_SETS);
	localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
	localparam int TAG_LSB = OFFSET_BITS + INDEX_BITS;
	localparam int NUM_WAYS = 4;
	localparam int WAY_BITS = $clog2(NUM_WAYS);

	// state bit meanings
	localparam int DIRTY_BIT = 2;		// M, O
	localparam int SHARED_BIT = 0;		// S, O

	typedef enum logic [2:0] {
		ST_I = 3'b000,
		ST_S = 3'b001,
		ST_E = 3'b010,
		ST_O = 3'b101,
		ST_M = 3'b110
	} moesi_t;

	typedef logic [LINE_BITS-1:0] line_t;
	typedef logic [TAG_BITS-1:0] tag_t;
	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [TAG_BITS+INDEX_BITS-1:0] line_addr_t;	// {tag, index}
	typedef logic [LINE_BYTES-1:0] byte_en_t;
	typedef logic [NUM_WAYS-1:0] way_vec_t;

endpackage
